// ==== source/mem_pkg.sv ====
// mem_pkg: data memory widths, byte-enable type and read-port fill patterns

package mem_pkg;

  // ******************************
  // bus widths
  // ******************************

  // byte address as issued by the core
  typedef logic [31:0] addr_t;

  // one data word of the memory
  typedef logic [31:0] word_t;

  // bit k enables byte lane k, i.e. bits 8k+7..8k of a word
  typedef logic [3:0]  byte_en_t;

  // ******************************
  // memory geometry
  // ******************************

  // 4096 words give a byte range of 0 .. 3fff
  localparam int MEM_WORDS_DEFAULT = 4096;

  // ******************************
  // read port fill patterns
  // ******************************

  // read port value in any cycle without a read (no request, or a store)
  localparam word_t READ_IDLE_WORD = 32'hFA11_1EAF;

  // read port value for a read above the memory range
  localparam word_t READ_OOR_WORD  = 32'hDEAD_BEEF;

endpackage

// ==== source/lsu_pkg.sv ====
// lsu_pkg: access size encoding and load-store unit state encoding

package lsu_pkg;

  // ******************************
  // access size
  // ******************************

  // same encoding as the risc-v funct3 field of loads and stores,
  // bit 2 set means the load result is zero-extended
  typedef enum logic [2:0] {
    LDST_B  = 3'd0,  // signed byte
    LDST_H  = 3'd1,  // signed halfword
    LDST_W  = 3'd2,  // word
    LDST_BU = 3'd4,  // unsigned byte
    LDST_HU = 3'd5   // unsigned halfword
  } mem_size_e;

  // ******************************
  // lsu state
  // ******************************

  // LSU_IDLE takes a new request and issues it to the memory,
  // LSU_WAIT is the cycle in which the read word comes back
  typedef enum logic {
    LSU_IDLE = 1'b0,
    LSU_WAIT = 1'b1
  } lsu_state_e;

endpackage

// ==== source/ext_mem.sv ====
// ext_mem: word-organised data memory with per-byte write enables and one-cycle read

module ext_mem #(
  parameter int MEM_WORDS = mem_pkg::MEM_WORDS_DEFAULT  // depth in words, power of two
) (
  input  logic             clk_i,
  input  logic             req_i,   // access request
  input  logic             we_i,    // 1 store, 0 load
  input  mem_pkg::byte_en_t be_i,   // byte lanes written by a store
  input  mem_pkg::addr_t   addr_i,  // byte address, low two bits ignored
  input  mem_pkg::word_t   wd_i,    // store data, already in its lanes
  output mem_pkg::word_t   rd_o     // registered read data
);

  import mem_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);  // word index width
  localparam int LANES = $bits(byte_en_t);    // byte lanes per word

  // ******************************
  // address decode
  // ******************************

  logic [IDX_W-1:0] word_idx;  // word index into the array
  logic             in_range;  // address lies inside the memory
  logic             wr_en;     // store to an existing word

  assign word_idx = addr_i[IDX_W+1:2];
  assign in_range = (addr_i[31:2] < 30'(MEM_WORDS));
  assign wr_en    = req_i && we_i && in_range;  // stores above the range are dropped

  // ******************************
  // storage
  // ******************************

  word_t mem_q [MEM_WORDS];

  // each enabled lane takes its byte of the store data
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int k = 0; k < LANES; k++) begin
        if (be_i[k]) begin
          mem_q[word_idx][8*k +: 8] <= wd_i[8*k +: 8];
        end
      end
    end
  end

  // ******************************
  // read port
  // ******************************

  // the port shows the idle pattern whenever no load is in progress,
  // so a consumer can tell a stale cycle from real data
  always_ff @(posedge clk_i) begin
    if (!req_i || we_i) begin
      rd_o <= READ_IDLE_WORD;    // no read this cycle
    end else if (in_range) begin
      rd_o <= mem_q[word_idx];
    end else begin
      rd_o <= READ_OOR_WORD;     // read above the range
    end
  end

endmodule

// ==== source/lsu.sv ====
// lsu: load-store unit turning core requests into memory accesses with a one-cycle stall

module lsu (
  input  logic               clk_i,
  input  logic               rst_i,

  // core side
  input  logic               core_req_i,    // held until the stall drops
  input  logic               core_we_i,     // 1 store, 0 load
  input  lsu_pkg::mem_size_e core_size_i,   // access size and signedness
  input  mem_pkg::addr_t     core_addr_i,   // byte address
  input  mem_pkg::word_t     core_wd_i,     // store data, right-aligned
  output mem_pkg::word_t     core_rd_o,     // extended load result
  output logic               core_stall_o,  // request not complete yet

  // memory side
  output logic               mem_req_o,
  output logic               mem_we_o,
  output mem_pkg::byte_en_t  mem_be_o,
  output mem_pkg::addr_t     mem_addr_o,    // word-aligned byte address
  output mem_pkg::word_t     mem_wd_o,      // store data moved into its lanes
  input  mem_pkg::word_t     mem_rd_i       // word returned one cycle later
);

  import mem_pkg::*;
  import lsu_pkg::*;

  // ******************************
  // state machine
  // ******************************

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       issue;  // request goes to the memory this cycle

  // a request is issued only from idle; in the wait cycle the core still
  // holds it, but the memory must not see it a second time
  assign issue = core_req_i && (state_q == LSU_IDLE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      LSU_IDLE: begin
        if (core_req_i) begin
          state_d = LSU_WAIT;
        end
      end
      LSU_WAIT: begin
        state_d = LSU_IDLE;  // read word is on mem_rd_i now
      end
      default: begin
        state_d = LSU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LSU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_stall_o = issue;  // high in the issue cycle only

  // ******************************
  // request conversion
  // ******************************

  byte_en_t be;        // lanes touched by the access
  word_t    wd_lanes;  // store data replicated over the lanes

  always_comb begin
    case (core_size_i)
      LDST_B, LDST_BU: begin
        be       = byte_en_t'(4'b0001 << core_addr_i[1:0]);
        wd_lanes = {4{core_wd_i[7:0]}};
      end
      LDST_H, LDST_HU: begin
        be       = core_addr_i[1] ? 4'b1100 : 4'b0011;  // bit 0 not used
        wd_lanes = {2{core_wd_i[15:0]}};
      end
      default: begin
        be       = 4'b1111;  // word
        wd_lanes = core_wd_i;
      end
    endcase
  end

  assign mem_req_o  = issue;
  assign mem_we_o   = issue && core_we_i;
  assign mem_be_o   = be;
  assign mem_addr_o = {core_addr_i[31:2], 2'b00};
  assign mem_wd_o   = wd_lanes;

  // ******************************
  // load extraction
  // ******************************

  // the core holds address and size through the wait cycle, so the
  // lane can be picked straight from the held request
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;
  word_t       rd_ext;

  always_comb begin
    case (core_addr_i[1:0])
      2'd0:    rd_byte = mem_rd_i[7:0];
      2'd1:    rd_byte = mem_rd_i[15:8];
      2'd2:    rd_byte = mem_rd_i[23:16];
      default: rd_byte = mem_rd_i[31:24];
    endcase
  end

  assign rd_half = core_addr_i[1] ? mem_rd_i[31:16] : mem_rd_i[15:0];

  always_comb begin
    case (core_size_i)
      LDST_B:  rd_ext = {{24{rd_byte[7]}}, rd_byte};   // sign-extend
      LDST_BU: rd_ext = {24'd0, rd_byte};
      LDST_H:  rd_ext = {{16{rd_half[15]}}, rd_half};  // sign-extend
      LDST_HU: rd_ext = {16'd0, rd_half};
      default: rd_ext = mem_rd_i;                      // whole word
    endcase
  end

  assign core_rd_o = rd_ext;

endmodule

// ==== source/dmem_lsu_top.sv ====
// dmem_lsu_top: load-store unit joined to the external data memory

module dmem_lsu_top #(
  parameter int MEM_WORDS = mem_pkg::MEM_WORDS_DEFAULT  // memory depth in words
) (
  input  logic               clk_i,
  input  logic               rst_i,

  // core side
  input  logic               core_req_i,
  input  logic               core_we_i,
  input  lsu_pkg::mem_size_e core_size_i,
  input  mem_pkg::addr_t     core_addr_i,
  input  mem_pkg::word_t     core_wd_i,
  output mem_pkg::word_t     core_rd_o,
  output logic               core_stall_o
);

  import mem_pkg::*;

  // ******************************
  // lsu to memory
  // ******************************

  logic     mem_req;
  logic     mem_we;
  byte_en_t mem_be;
  addr_t    mem_addr;
  word_t    mem_wd;
  word_t    mem_rd;  // registered read data back to the lsu

  lsu u_lsu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_req_i   (core_req_i),
    .core_we_i    (core_we_i),
    .core_size_i  (core_size_i),
    .core_addr_i  (core_addr_i),
    .core_wd_i    (core_wd_i),
    .core_rd_o    (core_rd_o),
    .core_stall_o (core_stall_o),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_be_o     (mem_be),
    .mem_addr_o   (mem_addr),
    .mem_wd_o     (mem_wd),
    .mem_rd_i     (mem_rd)
  );

  ext_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk_i  (clk_i),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .be_i   (mem_be),
    .addr_i (mem_addr),
    .wd_i   (mem_wd),
    .rd_o   (mem_rd)
  );

endmodule

// ==== tests/tb_dmem_lsu_tasks.svh ====
// dmem_lsu test tasks: core access, result compares and the directed tests

`ifndef TB_DMEM_LSU_TASKS_SVH
`define TB_DMEM_LSU_TASKS_SVH

  // ******************************
  // compares
  // ******************************

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // ******************************
  // core accesses
  // ******************************

  // one request, held until the stall drops; stall must last exactly one cycle
  task automatic do_access(input logic we, input mem_size_e size, input addr_t addr,
                           input word_t wd, output word_t rd);
    int waited;
    @(posedge clk_i);
    core_req_i  <= 1'b1;
    core_we_i   <= we;
    core_size_i <= size;
    core_addr_i <= addr;
    core_wd_i   <= wd;
    @(negedge clk_i);
    check_bit("core_stall_o", core_stall_o, 1'b1);  // request cycle
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (core_stall_o && waited < STALL_TIMEOUT);
    if (core_stall_o) begin
      stop_on_error("timeout waiting for core_stall_o to drop");
    end else if (waited != 1) begin
      stop_on_error($sformatf("core_stall_o stayed high for %0d cycles", waited));
    end
    rd = core_rd_o;  // load result valid while the stall is low
    @(posedge clk_i);
    core_req_i <= 1'b0;
    core_we_i  <= 1'b0;
    @(negedge clk_i);
    check_bit("core_stall_o", core_stall_o, 1'b0);  // idle again
  endtask

  task automatic store_access(input mem_size_e size, input addr_t addr, input word_t wd);
    word_t ignored_rd;
    do_access(1'b1, size, addr, wd, ignored_rd);
    shadow_store(size, addr, wd);
  endtask

  task automatic load_check(input mem_size_e size, input addr_t addr);
    word_t got;
    word_t exp;
    exp = expected_load(size, addr);
    do_access(1'b0, size, addr, 32'h0, got);
    check_word("core_rd_o", got, exp);
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_reset_idle();
    repeat (3) begin
      @(negedge clk_i);
      check_bit("core_stall_o", core_stall_o, 1'b0);
    end
  endtask

  task automatic test_word_round_trip();
    addr_t addrs [8];
    addrs[0] = '0;  // both ends of the range
    addrs[1] = addr_t'(MEM_BYTES - 4);
    for (int i = 2; i < 8; i++) begin
      addrs[i] = take_bits(IDX_W) << 2;
    end
    for (int i = 0; i < 8; i++) begin
      store_access(LDST_W, addrs[i], take_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      load_check(LDST_W, addrs[i]);
    end
  endtask

  task automatic test_partial_stores();
    addr_t base;
    base = take_bits(IDX_W) << 2;
    store_access(LDST_W, base, take_bits(32));
    for (int lane = 0; lane < 4; lane++) begin
      store_access(LDST_B, base + addr_t'(lane), take_bits(32));  // upper bits must be ignored
      load_check(LDST_W, base);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      store_access(LDST_H, base + addr_t'(lane), take_bits(32));
      load_check(LDST_W, base);
    end
  endtask

  task automatic test_load_extension();
    addr_t base;
    word_t pattern;
    for (int round = 0; round < 2; round++) begin
      base    = take_bits(IDX_W) << 2;
      pattern = take_bits(32);
      if (round == 0) begin
        pattern = pattern | 32'h8080_8080;  // every byte negative
      end else begin
        pattern = pattern & 32'h7f7f_7f7f;
      end
      store_access(LDST_W, base, pattern);
      for (int lane = 0; lane < 4; lane++) begin
        load_check(LDST_B, base + addr_t'(lane));
        load_check(LDST_BU, base + addr_t'(lane));
      end
      for (int lane = 0; lane < 4; lane += 2) begin
        load_check(LDST_H, base + addr_t'(lane));
        load_check(LDST_HU, base + addr_t'(lane));
      end
    end
  endtask

  task automatic test_out_of_range();
    addr_t low;
    addr_t high;
    low  = take_bits(IDX_W) << 2;
    high = low + addr_t'(MEM_BYTES);  // same word index as low
    store_access(LDST_W, low, take_bits(32));
    load_check(LDST_W, high);
    store_access(LDST_W, high, take_bits(32));
    load_check(LDST_W, low);
    load_check(LDST_W, 32'hFFFF_FFFC);
    load_check(LDST_BU, high + addr_t'(1));
  endtask

`endif

// ==== tests/tb_dmem_lsu.sv ====
// tb_dmem_lsu: directed testbench for the load-store unit and data memory

module tb_dmem_lsu;

  import mem_pkg::*;
  import lsu_pkg::*;

  localparam int          MEM_WORDS     = 1024;           // smaller than the default depth
  localparam int          MEM_BYTES     = MEM_WORDS * 4;
  localparam int          IDX_W         = $clog2(MEM_WORDS);
  localparam int          RESET_CYCLES  = 4;
  localparam int          STALL_TIMEOUT = 16;             // cycles before a wait gives up
  localparam logic [31:0] LFSR_SEED     = 32'hdf4953b7;

  logic      clk_i;
  logic      rst_i;
  logic      core_req_i;
  logic      core_we_i;
  mem_size_e core_size_i;
  addr_t     core_addr_i;
  word_t     core_wd_i;
  word_t     core_rd_o;
  logic      core_stall_o;

  logic [31:0] lfsr_state;      // random source for addresses and data
  logic [7:0]  shadow [MEM_BYTES];  // reference copy of the memory, one entry per byte

  always #2 clk_i = ~clk_i;

  dmem_lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_req_i   (core_req_i),
    .core_we_i    (core_we_i),
    .core_size_i  (core_size_i),
    .core_addr_i  (core_addr_i),
    .core_wd_i    (core_wd_i),
    .core_rd_o    (core_rd_o),
    .core_stall_o (core_stall_o)
  );

  // ******************************
  // random numbers
  // ******************************

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit, bits collected right-aligned
  function automatic word_t take_bits(input int nbits);
    word_t val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // ******************************
  // reference model
  // ******************************

  // a store touches 1, 2 or 4 bytes starting at its lane; nothing above the range
  task automatic shadow_store(input mem_size_e size, input addr_t addr, input word_t wd);
    int base;
    int first;
    int count;
    base = int'({addr[31:2], 2'b00});
    case (size)
      LDST_B, LDST_BU: begin
        first = int'(addr[1:0]);
        count = 1;
      end
      LDST_H, LDST_HU: begin
        first = addr[1] ? 2 : 0;
        count = 2;
      end
      default: begin
        first = 0;
        count = 4;
      end
    endcase
    if (addr < addr_t'(MEM_BYTES)) begin
      for (int k = 0; k < count; k++) begin
        shadow[base + first + k] = wd[8*k +: 8];
      end
    end
  endtask

  // predicted core_rd_o for a load of the given size
  function automatic word_t expected_load(input mem_size_e size, input addr_t addr);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    int          base;
    int          lane;
    base = int'({addr[31:2], 2'b00});
    lane = int'(addr[1:0]);
    if (addr >= addr_t'(MEM_BYTES)) begin
      w = 32'hDEAD_BEEF;  // read above the range
    end else begin
      w = {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    end
    b = w[8*lane +: 8];
    h = addr[1] ? w[31:16] : w[15:0];
    case (size)
      LDST_B:  return {{24{b[7]}}, b};
      LDST_BU: return {24'h0, b};
      LDST_H:  return {{16{h[15]}}, h};
      LDST_HU: return {16'h0, h};
      default: return w;
    endcase
  endfunction

  `include "tb_dmem_lsu_tasks.svh"

  // ******************************
  // test sequence
  // ******************************

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    core_req_i  = 1'b0;
    core_we_i   = 1'b0;
    core_size_i = LDST_W;
    core_addr_i = '0;
    core_wd_i   = '0;
    lfsr_state  = LFSR_SEED;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset_idle();
    test_word_round_trip();
    test_partial_stores();
    test_load_extension();
    test_out_of_range();
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== dmem_lsu.f ====
+incdir+tests
source/mem_pkg.sv
source/lsu_pkg.sv
source/ext_mem.sv
source/lsu.sv
source/dmem_lsu_top.sv
tests/tb_dmem_lsu.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the dmem_lsu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module tb_dmem_lsu \
  -f dmem_lsu.f \
  -o tb_dmem_lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_dmem_lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0
